/* common/rvb_settings.svh */
`ifndef RVB_SETTINGS_SVH
`define RVB_SETTINGS_SVH

// Operand and result width of the unit
`define RVB_XLEN 32

// Shift amount and bit index width
`define RVB_SHAMT_W 5

`endif

/* common/rvb_isa_pkg.sv */
package rvb_isa_pkg;

	// Immediate shifts share the opcode of their register form
	typedef enum logic [3:0] {
		OP_NONE,
		OP_ANDN,
		OP_ORN,
		OP_XNOR,
		OP_MIN,
		OP_MAX,
		OP_MINU,
		OP_MAXU,
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_ROL,
		OP_ROR,
		OP_CLZ,
		OP_CTZ,
		OP_PCNT
	} rvb_op_t;

	typedef enum logic [1:0] {
		UNIT_NONE,
		UNIT_LOGIC,   // Single cycle logic, min/max and shifts
		UNIT_COUNT    // Iterative bit counter
	} rvb_unit_t;

endpackage

/* common/rvb_ctrl_pkg.sv */
package rvb_ctrl_pkg;

	// One instruction in flight at a time
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_EXEC,
		ST_HOLD
	} rvb_state_t;

endpackage

/* src/rvb_decoder.sv */
`timescale 1ns/100ps

module rvb_decoder (
	input  logic [31:0]            insn,
	output rvb_isa_pkg::rvb_op_t   op,
	output rvb_isa_pkg::rvb_unit_t unit,
	output logic                   decoded
);
	import rvb_isa_pkg::*;

	logic [21:0] key;   // funct7, rs2 field, funct3, major opcode

	assign key = {insn[31:25], insn[24:20], insn[14:12], insn[6:0]};

	always_comb begin
		op = OP_NONE;
		unique casez (key)
			22'b0100000_zzzzz_111_0110011: op = OP_ANDN;
			22'b0100000_zzzzz_110_0110011: op = OP_ORN;
			22'b0100000_zzzzz_100_0110011: op = OP_XNOR;
			22'b0000101_zzzzz_100_0110011: op = OP_MIN;
			22'b0000101_zzzzz_101_0110011: op = OP_MAX;
			22'b0000101_zzzzz_110_0110011: op = OP_MINU;
			22'b0000101_zzzzz_111_0110011: op = OP_MAXU;
			22'b0000000_zzzzz_001_0110011: op = OP_SLL;
			22'b0000000_zzzzz_101_0110011: op = OP_SRL;
			22'b0100000_zzzzz_101_0110011: op = OP_SRA;
			22'b0110000_zzzzz_001_0110011: op = OP_ROL;
			22'b0110000_zzzzz_101_0110011: op = OP_ROR;
			22'b0000000_zzzzz_001_0010011: op = OP_SLL;    // SLLI
			22'b0000000_zzzzz_101_0010011: op = OP_SRL;    // SRLI
			22'b0100000_zzzzz_101_0010011: op = OP_SRA;    // SRAI
			22'b0110000_zzzzz_101_0010011: op = OP_ROR;    // RORI
			22'b0110000_00000_001_0010011: op = OP_CLZ;
			22'b0110000_00001_001_0010011: op = OP_CTZ;
			22'b0110000_00010_001_0010011: op = OP_PCNT;
			default: op = OP_NONE;
		endcase
	end

	// Unit follows from the opcode
	always_comb begin
		case (op)
			OP_NONE: unit = UNIT_NONE;
			OP_CLZ,
			OP_CTZ,
			OP_PCNT: unit = UNIT_COUNT;
			default: unit = UNIT_LOGIC;
		endcase
	end

	assign decoded = (unit != UNIT_NONE);

endmodule

/* src/rvb_pipe_regs.sv */
`timescale 1ns/100ps
`include "rvb_settings.svh"

module rvb_pipe_regs (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   accept,
	input  logic                   capture,
	input  logic [31:0]            insn,
	input  logic [`RVB_XLEN-1:0]   rs1,
	input  logic [`RVB_XLEN-1:0]   rs2,
	input  rvb_isa_pkg::rvb_op_t   op_in,
	input  rvb_isa_pkg::rvb_unit_t unit_in,
	input  logic [`RVB_XLEN-1:0]   logic_result,
	input  logic [`RVB_XLEN-1:0]   count_result,
	output rvb_isa_pkg::rvb_op_t   op_q,
	output rvb_isa_pkg::rvb_unit_t unit_q,
	output logic [`RVB_XLEN-1:0]   rs1_q,
	output logic [`RVB_XLEN-1:0]   rs2_q,
	output logic [`RVB_XLEN-1:0]   rd
);
	import rvb_isa_pkg::*;

	logic [`RVB_XLEN-1:0] imm_ext;   // Sign-extended I-type immediate

	assign imm_ext = {{(`RVB_XLEN-12){insn[31]}}, insn[31:20]};

	always_ff @(posedge clock) begin
		if (reset) begin
			op_q   <= OP_NONE;
			unit_q <= UNIT_NONE;
		end else if (accept) begin
			op_q   <= op_in;
			unit_q <= unit_in;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			rs1_q <= rs1;
			rs2_q <= insn[5] ? rs2 : imm_ext;   // Bit 5 set for R-type
		end
		if (capture) begin
			rd <= (unit_q == UNIT_COUNT) ? count_result : logic_result;
		end
	end

endmodule

/* src/rvb_issue_fsm.sv */
`timescale 1ns/100ps

module rvb_issue_fsm (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   din_valid,
	input  logic                   decoded,
	input  rvb_isa_pkg::rvb_unit_t unit_q,
	input  logic                   count_done,
	input  logic                   dout_ready,
	output logic                   din_ready,
	output logic                   accept,
	output logic                   count_start,
	output logic                   capture,
	output logic                   dout_valid
);
	import rvb_isa_pkg::*;
	import rvb_ctrl_pkg::*;

	rvb_state_t state;
	rvb_state_t state_next;
	logic       armed;        // Low until the first cycle after reset
	logic       exec_first;   // First cycle of ST_EXEC
	logic       exec_done;

	// Logic unit finishes in one cycle
	assign exec_done = (unit_q == UNIT_COUNT) ? count_done : 1'b1;

	assign din_ready   = armed && (state == ST_IDLE) && decoded;
	assign accept      = din_ready && din_valid;
	assign count_start = (state == ST_EXEC) && exec_first && (unit_q == UNIT_COUNT);
	assign capture     = (state == ST_EXEC) && exec_done;
	assign dout_valid  = (state == ST_HOLD);

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: if (accept) state_next = ST_EXEC;
			ST_EXEC: if (exec_done) state_next = ST_HOLD;
			ST_HOLD: if (dout_ready) state_next = ST_IDLE;
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= ST_IDLE;
			armed      <= 1'b0;
			exec_first <= 1'b0;
		end else begin
			state      <= state_next;
			armed      <= 1'b1;
			exec_first <= accept;
		end
	end

endmodule

/* src/rvb_bitlogic.sv */
`timescale 1ns/100ps
`include "rvb_settings.svh"

module rvb_bitlogic (
	input  rvb_isa_pkg::rvb_op_t op,
	input  logic [`RVB_XLEN-1:0] rs1,
	input  logic [`RVB_XLEN-1:0] rs2,
	output logic [`RVB_XLEN-1:0] result
);
	import rvb_isa_pkg::*;

	logic [`RVB_SHAMT_W-1:0] shamt;        // Low bits of rs2 only
	logic                    less_signed;
	logic                    less_unsigned;
	logic [2*`RVB_XLEN-1:0]  rol_wide;     // Doubled word shifted left
	logic [2*`RVB_XLEN-1:0]  ror_wide;     // Doubled word shifted right

	assign shamt         = rs2[`RVB_SHAMT_W-1:0];
	assign less_signed   = $signed(rs1) < $signed(rs2);
	assign less_unsigned = rs1 < rs2;
	assign rol_wide      = {rs1, rs1} << shamt;
	assign ror_wide      = {rs1, rs1} >> shamt;

	always_comb begin
		case (op)
			OP_ANDN: result = rs1 & ~rs2;
			OP_ORN:  result = rs1 | ~rs2;
			OP_XNOR: result = rs1 ^ ~rs2;
			OP_MIN:  result = less_signed ? rs1 : rs2;
			OP_MAX:  result = less_signed ? rs2 : rs1;
			OP_MINU: result = less_unsigned ? rs1 : rs2;
			OP_MAXU: result = less_unsigned ? rs2 : rs1;
			OP_SLL:  result = rs1 << shamt;
			OP_SRL:  result = rs1 >> shamt;
			OP_SRA:  result = $signed(rs1) >>> shamt;
			OP_ROL:  result = rol_wide[2*`RVB_XLEN-1:`RVB_XLEN];
			OP_ROR:  result = ror_wide[`RVB_XLEN-1:0];
			default: result = '0;   // Count opcodes and OP_NONE
		endcase
	end

endmodule

/* src/rvb_bitcount.sv */
`timescale 1ns/100ps
`include "rvb_settings.svh"

module rvb_bitcount (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 count_start,
	input  rvb_isa_pkg::rvb_op_t op,
	input  logic [`RVB_XLEN-1:0] rs1,
	output logic [`RVB_XLEN-1:0] result,
	output logic                 count_done
);
	import rvb_isa_pkg::*;

	localparam int LAST_BIT = `RVB_XLEN - 1;

	logic [`RVB_XLEN-1:0]    scan;        // Bits not yet examined
	logic [`RVB_SHAMT_W:0]   count;
	logic [`RVB_SHAMT_W-1:0] index;       // Steps taken so far
	logic                    busy;
	logic                    hit;         // Stop after this step
	logic                    inc;
	logic                    last_step;
	logic [`RVB_SHAMT_W:0]   count_sum;

	always_comb begin
		hit = 1'b1;
		inc = 1'b0;
		case (op)
			OP_CLZ: begin
				hit = scan[`RVB_XLEN-1];
				inc = ~scan[`RVB_XLEN-1];
			end
			OP_CTZ: begin
				hit = scan[0];
				inc = ~scan[0];
			end
			OP_PCNT: begin
				hit = (scan == '0);   // Nothing left to count
				inc = scan[0];
			end
			default: ;
		endcase
	end

	assign last_step  = busy && (hit || index == LAST_BIT[`RVB_SHAMT_W-1:0]);
	assign count_sum  = count + {{`RVB_SHAMT_W{1'b0}}, inc};
	assign count_done = last_step;
	assign result     = {{(`RVB_XLEN-`RVB_SHAMT_W-1){1'b0}}, count_sum};

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (count_start) begin
			busy <= 1'b1;
		end else if (last_step) begin
			busy <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (count_start) begin
			scan  <= rs1;
			count <= '0;
			index <= '0;
		end else if (busy) begin
			count <= count_sum;
			index <= index + 1'b1;
			// CLZ scans from the top, the others from bit 0
			scan  <= (op == OP_CLZ) ? (scan << 1) : (scan >> 1);
		end
	end

endmodule

/* src/rvb_full.sv */
`timescale 1ns/100ps
`include "rvb_settings.svh"

module rvb_full (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 din_valid,
	output logic                 din_ready,
	output logic                 din_decoded,
	input  logic [31:0]          din_insn,
	input  logic [`RVB_XLEN-1:0] din_rs1,
	input  logic [`RVB_XLEN-1:0] din_rs2,
	output logic                 dout_valid,
	input  logic                 dout_ready,
	output logic [`RVB_XLEN-1:0] dout_rd
);
	import rvb_isa_pkg::*;

	rvb_op_t              dec_op;
	rvb_unit_t            dec_unit;
	rvb_op_t              op_q;
	rvb_unit_t            unit_q;
	logic [`RVB_XLEN-1:0] rs1_q;
	logic [`RVB_XLEN-1:0] rs2_q;        // Register value or immediate
	logic [`RVB_XLEN-1:0] logic_result;
	logic [`RVB_XLEN-1:0] count_result;
	logic                 accept;
	logic                 capture;
	logic                 count_start;
	logic                 count_done;

	rvb_decoder i_decoder (
		.insn    (din_insn),
		.op      (dec_op),
		.unit    (dec_unit),
		.decoded (din_decoded)
	);

	rvb_pipe_regs i_pipe_regs (
		.clock        (clock),
		.reset        (reset),
		.accept       (accept),
		.capture      (capture),
		.insn         (din_insn),
		.rs1          (din_rs1),
		.rs2          (din_rs2),
		.op_in        (dec_op),
		.unit_in      (dec_unit),
		.logic_result (logic_result),
		.count_result (count_result),
		.op_q         (op_q),
		.unit_q       (unit_q),
		.rs1_q        (rs1_q),
		.rs2_q        (rs2_q),
		.rd           (dout_rd)
	);

	rvb_issue_fsm i_issue_fsm (
		.clock       (clock),
		.reset       (reset),
		.din_valid   (din_valid),
		.decoded     (din_decoded),
		.unit_q      (unit_q),
		.count_done  (count_done),
		.dout_ready  (dout_ready),
		.din_ready   (din_ready),
		.accept      (accept),
		.count_start (count_start),
		.capture     (capture),
		.dout_valid  (dout_valid)
	);

	rvb_bitlogic i_bitlogic (
		.op     (op_q),
		.rs1    (rs1_q),
		.rs2    (rs2_q),
		.result (logic_result)
	);

	rvb_bitcount i_bitcount (
		.clock       (clock),
		.reset       (reset),
		.count_start (count_start),
		.op          (op_q),
		.rs1         (rs1_q),
		.result      (count_result),
		.count_done  (count_done)
	);

endmodule

/* testbench/rvb_tb.sv */
`timescale 1ns/100ps
`include "rvb_settings.svh"

module rvb_tb_clock (
	output logic clock
);
	initial clock = 1'b0;
	always #2 clock = ~clock;   // 4 ns period
endmodule

module rvb_tb;
	logic                 clock;
	logic                 reset;
	logic                 din_valid;
	logic                 din_ready;
	logic                 din_decoded;
	logic [31:0]          din_insn;
	logic [`RVB_XLEN-1:0] din_rs1;
	logic [`RVB_XLEN-1:0] din_rs2;
	logic                 dout_valid;
	logic                 dout_ready = 1'b0;
	logic [`RVB_XLEN-1:0] dout_rd;
	logic [31:0]          lfsr_state = 32'h28f1;
	logic                 stalled;     // Output held back at the last edge
	logic [`RVB_XLEN-1:0] held_rd;
	logic                 in_flight;
	int                   mismatch_count = 0;
	int                   timeout_count = 0;
	int                   other_count = 0;
	int                   accepts = 0;
	int                   outputs = 0;

	rvb_tb_clock i_clock (.clock(clock));

	rvb_full i_dut (
		.clock       (clock),
		.reset       (reset),
		.din_valid   (din_valid),
		.din_ready   (din_ready),
		.din_decoded (din_decoded),
		.din_insn    (din_insn),
		.din_rs1     (din_rs1),
		.din_rs2     (din_rs2),
		.dout_valid  (dout_valid),
		.dout_ready  (dout_ready),
		.dout_rd     (dout_rd)
	);

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] value);
		lfsr_step = value[0] ? ((value >> 1) ^ 32'h8020_0003) : (value >> 1);
	endfunction

	always @(posedge clock) begin
		lfsr_state = lfsr_step(lfsr_state);
		dout_ready <= lfsr_state[0];   // One step per bit
	end

	// Output stability and single instruction in flight
	always @(posedge clock) begin
		if (reset) begin
			stalled   <= 1'b0;
			in_flight <= 1'b0;
		end else begin
			if (stalled) begin
				assert (dout_valid && dout_rd == held_rd) else begin
					mismatch_count++;
					$display("mismatch at %0t: output changed before it was taken", $time);
				end
			end
			if (in_flight) begin
				assert (!din_ready) else begin
					mismatch_count++;
					$display("mismatch at %0t: din_ready high while busy", $time);
				end
			end
			stalled <= dout_valid && !dout_ready;
			held_rd <= dout_rd;
			if (din_valid && din_ready) begin
				accepts++;
				in_flight <= 1'b1;
			end
			if (dout_valid && dout_ready) begin
				outputs++;
				in_flight <= 1'b0;
			end
		end
	end

	task automatic issue_insn(input logic [31:0] insn, input logic [31:0] rs1,
			input logic [31:0] rs2);
		int   waited;
		logic taken;
		din_valid <= 1'b1;
		din_insn  <= insn;
		din_rs1   <= rs1;
		din_rs2   <= rs2;
		taken = 1'b0;
		waited = 0;
		while (!taken && waited < 100) begin
			@(posedge clock);
			waited++;
			taken = din_valid && din_ready;
		end
		assert (din_decoded) else begin
			mismatch_count++;
			$display("mismatch at %0t: word %h was not decoded", $time, insn);
		end
		din_valid <= 1'b0;
		assert (taken) else begin
			timeout_count++;
			$display("timeout: instruction %h was never accepted", insn);
		end
	endtask

	task automatic collect_result(input logic [31:0] insn, input logic [31:0] expected);
		int   waited;
		int   first_valid;
		logic done;
		logic is_count;
		// CLZ, CTZ and PCNT share funct7, funct3 and the OP-IMM opcode
		is_count = insn[31:25] == 7'b0110000 && insn[14:12] == 3'b001 &&
			insn[6:0] == 7'b0010011;
		done = 1'b0;
		waited = 0;
		first_valid = 0;
		while (!done && waited < 100) begin
			@(posedge clock);
			waited++;
			if (dout_valid && first_valid == 0)
				first_valid = waited;
			done = dout_valid && dout_ready;
		end
		assert (done) else begin
			timeout_count++;
			$display("timeout: no result came out for instruction %h", insn);
		end
		if (done) begin
			assert (dout_rd == expected) else begin
				mismatch_count++;
				$display("mismatch at %0t: insn %h gave %h, expected %h",
					$time, insn, dout_rd, expected);
			end
			assert (is_count || first_valid == 2) else begin
				mismatch_count++;
				$display("mismatch at %0t: insn %h valid after %0d cycles, expected 2",
					$time, insn, first_valid);
			end
		end
	endtask

	task automatic check_reject(input logic [31:0] insn);
		din_valid <= 1'b1;
		din_insn  <= insn;
		din_rs1   <= '0;
		din_rs2   <= '0;
		repeat (4) begin
			@(posedge clock);
			assert (!din_decoded && !din_ready && !dout_valid) else begin
				mismatch_count++;
				$display("mismatch at %0t: word %h was not rejected", $time, insn);
			end
		end
		din_valid <= 1'b0;
	endtask

	initial begin
		int          fd;
		int          fields;
		string       line;
		logic [31:0] insn;
		logic [31:0] rs1;
		logic [31:0] rs2;
		logic [31:0] expected;
		reset     <= 1'b1;
		din_valid <= 1'b0;
		din_insn  <= '0;
		din_rs1   <= '0;
		din_rs2   <= '0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		assert (!dout_valid && !din_ready) else begin
			mismatch_count++;
			$display("mismatch at %0t: handshake outputs high after reset", $time);
		end
		fd = $fopen("testbench/rvb_testdata.txt", "r");
		if (fd == 0) begin
			other_count++;
			$display("could not open the test vector file");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line[0] == "#")
					continue;
				fields = $sscanf(line, "%h %h %h %h", insn, rs1, rs2, expected);
				if (fields != 4) begin
					other_count++;
					$display("badly formed test vector line: %s", line);
				end else if (expected == 32'hffff_ffff) begin
					check_reject(insn);
				end else begin
					issue_insn(insn, rs1, rs2);
					collect_result(insn, expected);
				end
			end
			$fclose(fd);
		end
		repeat (2) @(posedge clock);
		assert (accepts == outputs) else begin
			mismatch_count++;
			$display("mismatch at %0t: %0d accepted, %0d results", $time, accepts, outputs);
		end
		$display("errors: %0d mismatch, %0d timeout, %0d other",
			mismatch_count, timeout_count, other_count);
		if (mismatch_count == 0 && timeout_count == 0 && other_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* testbench/rvb_testdata.txt */
# Columns: instruction word, rs1, rs2, expected rd (hex)
# An expected rd of ffffffff marks a word that must not decode
403170b3 f0f01234 0ff000ff f0001200
403160b3 12340000 ffff00ff 1234ff00
403140b3 aaaa5555 0f0f0f0f 5a5aa5a5
0a3140b3 fffffff0 00000010 fffffff0
0a3150b3 fffffff0 00000010 00000010
0a3160b3 fffffff0 00000010 00000010
0a3170b3 fffffff0 00000010 fffffff0
0a3140b3 80000000 7fffffff 80000000
0a3160b3 80000000 7fffffff 7fffffff
003110b3 000000f1 00000024 00000f10
003150b3 f0000000 00000044 0f000000
403150b3 80000000 ffffffe8 ff800000
603110b3 80000001 00000021 00000003
603150b3 00000001 0000003f 00000002
00411093 00001234 00000010 00012340
00815093 12345678 00000001 00123456
40c15093 87654321 00000002 fff87654
60415093 12345678 00000003 81234567
60011093 00010000 00000000 0000000f
60011093 00000000 00000000 00000020
60011093 ffffffff 00000000 00000000
60111093 00010000 00000000 00000010
60111093 00000000 00000000 00000020
60111093 ffffffff 00000000 00000000
60211093 00000000 00000000 00000000
60211093 ffffffff 00000000 00000020
60211093 f0f00001 00000000 00000009
003100b3 00000000 00000000 ffffffff
00000013 00000000 00000000 ffffffff
60311093 00000000 00000000 ffffffff
ffffffff 00000000 00000000 ffffffff

/* compile.f */
+incdir+common
common/rvb_isa_pkg.sv
common/rvb_ctrl_pkg.sv
src/rvb_decoder.sv
src/rvb_pipe_regs.sv
src/rvb_issue_fsm.sv
src/rvb_bitlogic.sv
src/rvb_bitcount.sv
src/rvb_full.sv
testbench/rvb_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module rvb_tb -o rvb_sim
./obj_dir/rvb_sim > sim.log
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
exit 0
